//--- Bender.yml
package:
  name: rv_soc

export_include_dirs:
  - common

sources:
  - common/rv_isa_pkg.sv
  - common/wb_pkg.sv
  - core/control.sv
  - core/rv_core.sv
  - hdl/wb_arbiter.sv
  - hdl/wb_ram.sv
  - hdl/rv_soc.sv
  - target: simulation
    files:
      - sim/rv_soc_properties.sv
      - sim/tb_rv_soc.sv

//--- common/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// datapath and bus width
`define RV_XLEN 32

// ram depth in 32-bit words
`define RV_MEM_WORDS 256

// first fetch address after run
`define RV_RESET_PC 32'h0000_0000

`define RV_HALT_OP 7'b1110011 // SYSTEM opcode, stops the core

`endif

//--- common/rv_isa_pkg.sv
`include "rv_defs.svh"
`default_nettype none

package rv_isa_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;    // register, alu and immediate value
    typedef logic [4:0]          reg_idx_t; // x0..x31

    typedef enum logic [6:0] {
        OP     = 7'b0110011,  // r-type alu
        OP_IMM = 7'b0010011,  // i-type alu
        LOAD   = 7'b0000011,  // lb, lw
        STORE  = 7'b0100011,  // sb, sw
        BRANCH = 7'b1100011,  // beq..bgeu
        SYSTEM = `RV_HALT_OP  // halt
    } opcode_e;

    // codes kept from the original alu control field
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SUB  = 4'b0001,
        AND  = 4'b0010,
        OR   = 4'b0011,
        XOR  = 4'b0100,
        SLT  = 4'b0101,
        SLTU = 4'b0110,
        SRL  = 4'b0111,
        SLL  = 4'b1000,
        SRA  = 4'b1001
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I = 3'b000,  // alu imm and loads
        IMM_S = 3'b001,  // stores
        IMM_B = 3'b010   // branch offset
    } imm_src_e;

endpackage

`default_nettype wire

//--- common/wb_pkg.sv
`include "rv_defs.svh"
`default_nettype none

package wb_pkg;

    typedef logic [`RV_XLEN-1:0]   wb_adr_t;  // byte address
    typedef logic [`RV_XLEN-1:0]   wb_dat_t;
    typedef logic [`RV_XLEN/8-1:0] wb_sel_t;  // one bit per byte lane

    typedef enum logic {
        OWN_CORE = 1'b0,
        OWN_HOST = 1'b1
    } wb_owner_e;

endpackage

`default_nettype wire

//--- core/control.sv
`timescale 1ns/100ps
`default_nettype none

module control import rv_isa_pkg::*; (
    input  opcode_e     op_i,            // instr[6:0]
    input  logic [2:0]  funct3_i,
    input  logic        funct7bit_i,     // instr[30]
    output logic        reg_write_en_o,  // write rd in wb
    output alu_op_e     alu_ctrl_o,
    output logic        alu_src_o,       // 1 = immediate operand
    output imm_src_e    imm_src_o,
    output logic        branch_src_o,    // pc from branch unit
    output logic        addr_select_o,   // 1 = word, 0 = byte access
    output logic        result_src_o,    // 1 = load data to rd
    output logic        mem_write_o,
    output logic        halt_o,
    output logic        illegal_o
);

    logic alt_op; // picks sub / sra

    // addi must never become a subtract, only srai uses bit 30 for imm ops
    assign alt_op = (op_i == OP) ? funct7bit_i : (funct7bit_i && (funct3_i == 3'b101));

    always_comb begin
        reg_write_en_o = 1'b0; // everything inactive unless decoded
        alu_ctrl_o     = ADD;  // address add for load / store
        alu_src_o      = 1'b0;
        imm_src_o      = IMM_I;
        branch_src_o   = 1'b0;
        addr_select_o  = 1'b1;
        result_src_o   = 1'b0;
        mem_write_o    = 1'b0;
        halt_o         = 1'b0;
        illegal_o      = 1'b0;

        case (op_i)
            OP, OP_IMM: begin
                reg_write_en_o = 1'b1;
                alu_src_o      = (op_i == OP_IMM);
                case (funct3_i)
                    3'b000: alu_ctrl_o = alt_op ? SUB : ADD;
                    3'b001: alu_ctrl_o = SLL;
                    3'b010: alu_ctrl_o = SLT;
                    3'b011: alu_ctrl_o = SLTU;
                    3'b100: alu_ctrl_o = XOR;
                    3'b101: alu_ctrl_o = alt_op ? SRA : SRL;
                    3'b110: alu_ctrl_o = OR;
                    3'b111: alu_ctrl_o = AND;
                endcase
            end
            LOAD: begin
                if (funct3_i == 3'b000 || funct3_i == 3'b010) begin // lb | lw
                    reg_write_en_o = 1'b1;
                    alu_src_o      = 1'b1;
                    result_src_o   = 1'b1;
                    addr_select_o  = funct3_i[1];
                end else begin
                    illegal_o = 1'b1; // lh, lbu, lhu not supported
                end
            end
            STORE: begin
                imm_src_o = IMM_S;
                if (funct3_i == 3'b000 || funct3_i == 3'b010) begin // sb | sw
                    alu_src_o     = 1'b1;
                    mem_write_o   = 1'b1;
                    addr_select_o = funct3_i[1];
                end else begin
                    illegal_o = 1'b1; // sh
                end
            end
            BRANCH: begin
                imm_src_o    = IMM_B;
                branch_src_o = 1'b1;
            end
            SYSTEM:  halt_o    = 1'b1;
            default: illegal_o = 1'b1; // lui, auipc, jal, jalr, unknown
        endcase
    end

endmodule

`default_nettype wire

//--- core/rv_core.sv
`include "rv_defs.svh"
`timescale 1ns/100ps
`default_nettype none

module rv_core import rv_isa_pkg::*, wb_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    run_i,      // start from reset pc
    output logic    wb_cyc_o,
    output logic    wb_stb_o,
    output logic    wb_we_o,
    output wb_adr_t wb_adr_o,
    output wb_sel_t wb_sel_o,
    output wb_dat_t wb_dat_o,
    input  wb_dat_t wb_dat_i,
    input  logic    wb_ack_i,
    output logic    halted_o,
    output logic    illegal_o
);

    typedef enum logic [2:0] {IDLE, FETCH, EXEC, MEM, WB, HALT} state_e;

    state_e   state_q;
    word_t    pc_q;
    word_t    ir_q;           // fetched instruction
    word_t    alu_q;          // alu result, also data address
    word_t    ld_q;           // load data, already extended
    logic     taken_q;
    logic     illegal_q;
    word_t    rf_q [1:31];    // x0 is not stored
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    imm;
    word_t    alu_b;
    word_t    alu_y;
    word_t    lane;           // load word shifted to the addressed byte
    word_t    ld_val;
    logic     taken;
    logic     reg_write_en;
    logic     alu_src;
    logic     branch_src;
    logic     addr_select;
    logic     result_src;
    logic     mem_write;
    logic     halt;
    logic     illegal;
    alu_op_e  alu_ctrl;
    imm_src_e imm_src;

    control u_control (
        .op_i           (opcode_e'(ir_q[6:0])),
        .funct3_i       (ir_q[14:12]),
        .funct7bit_i    (ir_q[30]),
        .reg_write_en_o (reg_write_en),
        .alu_ctrl_o     (alu_ctrl),
        .alu_src_o      (alu_src),
        .imm_src_o      (imm_src),
        .branch_src_o   (branch_src),
        .addr_select_o  (addr_select),
        .result_src_o   (result_src),
        .mem_write_o    (mem_write),
        .halt_o         (halt),
        .illegal_o      (illegal)
    );

    assign rs1     = ir_q[19:15];
    assign rs2     = ir_q[24:20];
    assign rd      = ir_q[11:7];
    assign rs1_val = (rs1 == '0) ? '0 : rf_q[rs1]; // x0 reads zero
    assign rs2_val = (rs2 == '0) ? '0 : rf_q[rs2];
    assign alu_b   = alu_src ? imm : rs2_val;

    always_comb begin
        case (imm_src)
            IMM_S:   imm = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
            IMM_B:   imm = {{19{ir_q[31]}}, ir_q[31], ir_q[7], ir_q[30:25], ir_q[11:8], 1'b0};
            default: imm = {{20{ir_q[31]}}, ir_q[31:20]}; // i-type
        endcase
    end

    always_comb begin
        case (alu_ctrl)
            SUB:     alu_y = rs1_val - alu_b;
            AND:     alu_y = rs1_val & alu_b;
            OR:      alu_y = rs1_val | alu_b;
            XOR:     alu_y = rs1_val ^ alu_b;
            SLT:     alu_y = word_t'($signed(rs1_val) < $signed(alu_b));
            SLTU:    alu_y = word_t'(rs1_val < alu_b);
            SRL:     alu_y = rs1_val >> alu_b[4:0];
            SLL:     alu_y = rs1_val << alu_b[4:0];
            SRA:     alu_y = word_t'($signed(rs1_val) >>> alu_b[4:0]);
            default: alu_y = rs1_val + alu_b; // add, address calc
        endcase
    end

    always_comb begin
        case (ir_q[14:12])
            3'b000:  taken = (rs1_val == rs2_val);                   // beq
            3'b001:  taken = (rs1_val != rs2_val);                   // bne
            3'b100:  taken = ($signed(rs1_val) < $signed(rs2_val));  // blt
            3'b101:  taken = ($signed(rs1_val) >= $signed(rs2_val)); // bge
            3'b110:  taken = (rs1_val < rs2_val);                    // bltu
            3'b111:  taken = (rs1_val >= rs2_val);                   // bgeu
            default: taken = 1'b0;
        endcase
    end

    assign lane   = wb_dat_i >> {alu_q[1:0], 3'b000};
    assign ld_val = addr_select ? wb_dat_i : {{24{lane[7]}}, lane[7:0]}; // lb sign-extends

    assign wb_cyc_o = (state_q == FETCH) || (state_q == MEM);
    assign wb_stb_o = wb_cyc_o;
    assign wb_we_o  = (state_q == MEM) && mem_write;
    assign wb_adr_o = (state_q == FETCH) ? pc_q : alu_q;
    assign wb_sel_o = ((state_q == FETCH) || addr_select) ? 4'b1111 : 4'b0001 << alu_q[1:0];
    assign wb_dat_o = addr_select ? rs2_val : {4{rs2_val[7:0]}}; // byte copied to all lanes

    // halt shows up already in the exec cycle of the stopping instruction
    assign halted_o  = (state_q == HALT) || ((state_q == EXEC) && (halt || illegal));
    assign illegal_o = illegal_q || ((state_q == EXEC) && illegal);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            pc_q      <= `RV_RESET_PC;
            illegal_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (run_i) begin
                        state_q <= FETCH;
                        pc_q    <= `RV_RESET_PC;
                    end
                end
                FETCH: if (wb_ack_i) state_q <= EXEC;
                EXEC: begin
                    if (halt || illegal) begin
                        state_q   <= HALT;
                        illegal_q <= illegal;
                    end else if (result_src || mem_write) begin
                        state_q <= MEM; // load or store
                    end else begin
                        state_q <= WB;
                    end
                end
                MEM: if (wb_ack_i) state_q <= WB;
                WB: begin
                    pc_q    <= taken_q ? pc_q + imm : pc_q + 32'd4;
                    state_q <= FETCH;
                end
                default: state_q <= HALT; // stays here until reset
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == FETCH && wb_ack_i) ir_q <= wb_dat_i;
        if (state_q == EXEC) begin
            alu_q   <= alu_y;
            taken_q <= branch_src && taken;
        end
        if (state_q == MEM && wb_ack_i) ld_q <= ld_val;
        if (state_q == WB && reg_write_en && rd != '0) begin
            rf_q[rd] <= result_src ? ld_q : alu_q;
        end
    end

endmodule

`default_nettype wire

//--- hdl/rv_soc.sv
`timescale 1ns/100ps
`default_nettype none

module rv_soc import wb_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    run_i,
    input  logic    host_cyc_i,   // host wishbone master
    input  logic    host_stb_i,
    input  logic    host_we_i,
    input  wb_adr_t host_adr_i,
    input  wb_sel_t host_sel_i,
    input  wb_dat_t host_dat_i,
    output wb_dat_t host_dat_o,
    output logic    host_ack_o,
    output logic    halted_o,
    output logic    illegal_o
);

    logic    core_cyc;
    logic    core_stb;
    logic    core_we;
    wb_adr_t core_adr;
    wb_sel_t core_sel;
    wb_dat_t core_dat_w;
    wb_dat_t core_dat_r;
    logic    core_ack;
    logic    ram_cyc;
    logic    ram_stb;
    logic    ram_we;
    wb_adr_t ram_adr;
    wb_sel_t ram_sel;
    wb_dat_t ram_dat_w;
    wb_dat_t ram_dat_r;
    logic    ram_ack;

    rv_core u_core (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .run_i     (run_i),
        .wb_cyc_o  (core_cyc),
        .wb_stb_o  (core_stb),
        .wb_we_o   (core_we),
        .wb_adr_o  (core_adr),
        .wb_sel_o  (core_sel),
        .wb_dat_o  (core_dat_w),
        .wb_dat_i  (core_dat_r),
        .wb_ack_i  (core_ack),
        .halted_o  (halted_o),
        .illegal_o (illegal_o)
    );

    wb_arbiter u_arbiter (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .m0_cyc_i (core_cyc),
        .m0_stb_i (core_stb),
        .m0_we_i  (core_we),
        .m0_adr_i (core_adr),
        .m0_sel_i (core_sel),
        .m0_dat_i (core_dat_w),
        .m0_dat_o (core_dat_r),
        .m0_ack_o (core_ack),
        .m1_cyc_i (host_cyc_i),
        .m1_stb_i (host_stb_i),
        .m1_we_i  (host_we_i),
        .m1_adr_i (host_adr_i),
        .m1_sel_i (host_sel_i),
        .m1_dat_i (host_dat_i),
        .m1_dat_o (host_dat_o),
        .m1_ack_o (host_ack_o),
        .s_cyc_o  (ram_cyc),
        .s_stb_o  (ram_stb),
        .s_we_o   (ram_we),
        .s_adr_o  (ram_adr),
        .s_sel_o  (ram_sel),
        .s_dat_o  (ram_dat_w),
        .s_dat_i  (ram_dat_r),
        .s_ack_i  (ram_ack)
    );

    wb_ram u_ram (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .cyc_i   (ram_cyc),
        .stb_i   (ram_stb),
        .we_i    (ram_we),
        .adr_i   (ram_adr),
        .sel_i   (ram_sel),
        .dat_i   (ram_dat_w),
        .dat_o   (ram_dat_r),
        .ack_o   (ram_ack)
    );

endmodule

`default_nettype wire

//--- hdl/wb_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module wb_arbiter import wb_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    m0_cyc_i,   // core master
    input  logic    m0_stb_i,
    input  logic    m0_we_i,
    input  wb_adr_t m0_adr_i,
    input  wb_sel_t m0_sel_i,
    input  wb_dat_t m0_dat_i,
    output wb_dat_t m0_dat_o,
    output logic    m0_ack_o,
    input  logic    m1_cyc_i,   // host master
    input  logic    m1_stb_i,
    input  logic    m1_we_i,
    input  wb_adr_t m1_adr_i,
    input  wb_sel_t m1_sel_i,
    input  wb_dat_t m1_dat_i,
    output wb_dat_t m1_dat_o,
    output logic    m1_ack_o,
    output logic    s_cyc_o,    // to the ram
    output logic    s_stb_o,
    output logic    s_we_o,
    output wb_adr_t s_adr_o,
    output wb_sel_t s_sel_o,
    output wb_dat_t s_dat_o,
    input  wb_dat_t s_dat_i,
    input  logic    s_ack_i
);

    wb_owner_e owner;     // grant for this cycle
    wb_owner_e last_q;    // owner of the latest transfer
    logic      busy_q;    // bus was held last cycle
    logic      last_cyc;

    assign last_cyc = (last_q == OWN_CORE) ? m0_cyc_i : m1_cyc_i;

    always_comb begin
        if (busy_q && last_cyc) begin
            owner = last_q; // keep grant while cyc stays up
        end else if (m0_cyc_i && m1_cyc_i) begin
            owner = (last_q == OWN_CORE) ? OWN_HOST : OWN_CORE; // tie goes to the other one
        end else if (m1_cyc_i) begin
            owner = OWN_HOST;
        end else begin
            owner = OWN_CORE; // parked on core
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            last_q <= OWN_HOST; // core wins the first tie
        end else begin
            busy_q <= s_cyc_o;
            if (s_cyc_o) last_q <= owner;
        end
    end

    assign s_cyc_o  = (owner == OWN_CORE) ? m0_cyc_i : m1_cyc_i;
    assign s_stb_o  = (owner == OWN_CORE) ? m0_stb_i : m1_stb_i;
    assign s_we_o   = (owner == OWN_CORE) ? m0_we_i  : m1_we_i;
    assign s_adr_o  = (owner == OWN_CORE) ? m0_adr_i : m1_adr_i;
    assign s_sel_o  = (owner == OWN_CORE) ? m0_sel_i : m1_sel_i;
    assign s_dat_o  = (owner == OWN_CORE) ? m0_dat_i : m1_dat_i;
    assign m0_dat_o = s_dat_i;                            // read data shared, ack decides
    assign m1_dat_o = s_dat_i;
    assign m0_ack_o = s_ack_i && (owner == OWN_CORE);
    assign m1_ack_o = s_ack_i && (owner == OWN_HOST);     // loser waits with ack low

endmodule

`default_nettype wire

//--- hdl/wb_ram.sv
`include "rv_defs.svh"
`timescale 1ns/100ps
`default_nettype none

module wb_ram import wb_pkg::*; #(
    parameter int MEM_WORDS = `RV_MEM_WORDS  // depth in 32-bit words
) (
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    cyc_i,
    input  logic    stb_i,
    input  logic    we_i,
    input  wb_adr_t adr_i,   // byte address, bits 1:0 ignored
    input  wb_sel_t sel_i,
    input  wb_dat_t dat_i,
    output wb_dat_t dat_o,
    output logic    ack_o
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    wb_dat_t          mem_q [MEM_WORDS];
    logic [IDX_W-1:0] idx;      // word index
    logic             ack_q;

    assign idx   = adr_i[IDX_W+1:2];
    assign ack_o = ack_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) ack_q <= 1'b0;
        else          ack_q <= cyc_i && stb_i && !ack_q; // one-cycle ack pulse
    end

    always_ff @(posedge clk_i) begin
        if (cyc_i && stb_i && !ack_q) dat_o <= mem_q[idx]; // valid during ack
        if (cyc_i && stb_i && we_i && ack_q) begin
            for (int b = 0; b < $bits(wb_sel_t); b++) begin
                if (sel_i[b]) mem_q[idx][8*b +: 8] <= dat_i[8*b +: 8]; // enabled lanes only
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/program_patterns.hex
// per run: word count, program words, check count, address and expected word pairs,
// then expected halted and illegal flags; a zero word count ends the list
00000040
06400093 FF900113 00200313 10000713
002081B3 40110233 406152B3 001123B3
00113433 0020C4B3 0020E533 0020F5B3
00609633 006156B3 40115813 40000893
00372023 00472223 00572423 00772623
00872823 00972A23 00A72C23 00B72E23
02C72023 02D72223 03072423 03172623
00000793 00300813 00178793 FFF80813
FE081CE3 00108463 00178793 00208463
00178793 00114463 00178793 0020C463
00178793 0020D463 00178793 00115463
00178793 0020E463 00178793 00116463
00178793 00117463 00178793 0020F463
00178793 02F72823 04172023 042700A3
042701A3 04170903 04070983 04072A03
05272223 05372423 05472623 00000073
00000011
00000100 0000005D  00000104 FFFFFF95  00000108 FFFFFFFE
0000010C 00000001  00000110 00000000  00000114 FFFFFF9D
00000118 FFFFFFFD  0000011C 00000060  00000120 00000190
00000124 3FFFFFFE  00000128 FFFFFFFC  0000012C 00000400
00000130 00000008  00000140 F900F964  00000144 FFFFFFF9
00000148 00000064  0000014C F900F964
00000001 00000000
// second run stops on an lh
00000005
05500093 18102023 18001103 18102223 00000073
00000002
00000180 00000055  00000184 00000000
00000001 00000001
00000000

//--- sim/rv_soc_properties.sv
`timescale 1ns/100ps
`default_nettype none

module rv_soc_properties import wb_pkg::*; (
    input logic      clk_i,
    input logic      rst_n_i,
    input logic      m0_cyc_i,
    input logic      m0_stb_i,
    input logic      m0_we_i,
    input wb_adr_t   m0_adr_i,
    input wb_sel_t   m0_sel_i,
    input wb_dat_t   m0_dat_i,
    input logic      m0_ack_o,
    input logic      m1_cyc_i,
    input logic      m1_stb_i,
    input logic      m1_we_i,
    input wb_adr_t   m1_adr_i,
    input wb_sel_t   m1_sel_i,
    input wb_dat_t   m1_dat_i,
    input logic      m1_ack_o,
    input logic      s_cyc_o,
    input wb_owner_e owner
);

    int fail_count = 0;    // failed assertions so far

    // an ack answers a request its own master made while granted
    core_ack_after_request: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        m0_ack_o |-> $past((owner == OWN_CORE) && m0_cyc_i && m0_stb_i))
        else begin
            $error("core ack without a granted core request");
            fail_count++;
        end

    host_ack_after_request: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        m1_ack_o |-> $past((owner == OWN_HOST) && m1_cyc_i && m1_stb_i))
        else begin
            $error("host ack without a granted host request");
            fail_count++;
        end

    core_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (m0_cyc_i && m0_stb_i && !m0_ack_o) |=> (m0_cyc_i && m0_stb_i
            && $stable(m0_we_i) && $stable(m0_adr_i) && $stable(m0_sel_i)
            && (!m0_we_i || $stable(m0_dat_i))))
        else begin
            $error("core request changed before ack");
            fail_count++;
        end

    host_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (m1_cyc_i && m1_stb_i && !m1_ack_o) |=> (m1_cyc_i && m1_stb_i
            && $stable(m1_we_i) && $stable(m1_adr_i) && $stable(m1_sel_i)
            && (!m1_we_i || $stable(m1_dat_i))))
        else begin
            $error("host request changed before ack");
            fail_count++;
        end

    // grant holds while the previous owner keeps cyc up
    owner_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        s_cyc_o |=> (!(($past(owner) == OWN_CORE) ? m0_cyc_i : m1_cyc_i)
            || (owner == $past(owner))))
        else begin
            $error("owner changed during a cycle");
            fail_count++;
        end

endmodule

bind wb_arbiter rv_soc_properties u_props (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .m0_cyc_i (m0_cyc_i),
    .m0_stb_i (m0_stb_i),
    .m0_we_i  (m0_we_i),
    .m0_adr_i (m0_adr_i),
    .m0_sel_i (m0_sel_i),
    .m0_dat_i (m0_dat_i),
    .m0_ack_o (m0_ack_o),
    .m1_cyc_i (m1_cyc_i),
    .m1_stb_i (m1_stb_i),
    .m1_we_i  (m1_we_i),
    .m1_adr_i (m1_adr_i),
    .m1_sel_i (m1_sel_i),
    .m1_dat_i (m1_dat_i),
    .m1_ack_o (m1_ack_o),
    .s_cyc_o  (s_cyc_o),
    .owner    (owner)
);

`default_nettype wire

//--- sim/tb_rv_soc.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_soc import rv_isa_pkg::*, wb_pkg::*; ();

    localparam int CLK_PERIOD    = 40;
    localparam int DRIVE_DELAY   = 2;    // after the rising edge
    localparam int PAT_DEPTH     = 512;
    localparam int MAX_POLL_WAIT = 3;    // core access of two cycles plus one
    localparam int MAX_ACK_WAIT  = 50;   // a host access that never completes

    logic    clk;
    logic    rst_n;
    logic    run;
    logic    host_cyc;
    logic    host_stb;
    logic    host_we;
    wb_adr_t host_adr;
    wb_sel_t host_sel;
    wb_dat_t host_dat_w;
    wb_dat_t host_dat_r;
    logic    host_ack;
    logic    halted;
    logic    illegal;

    logic [31:0] pat [PAT_DEPTH];    // pattern file image
    logic [31:0] lfsr_q;
    int          total_words;        // program words of all runs
    logic        patterns_ready;

    rv_soc UUT (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .run_i      (run),
        .host_cyc_i (host_cyc),
        .host_stb_i (host_stb),
        .host_we_i  (host_we),
        .host_adr_i (host_adr),
        .host_sel_i (host_sel),
        .host_dat_i (host_dat_w),
        .host_dat_o (host_dat_r),
        .host_ack_o (host_ack),
        .halted_o   (halted),
        .illegal_o  (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at %0t ns: %s is %h, expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at %0t ns: %s is %b, expected %b",
                                     $time, name, got, exp));
        end
    endtask

    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // galois form with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val    = (val << 1) | int'(lfsr_q[0]);    // one step per bit
        end
    endtask

    // classic cycle holds the request until ack and releases it after the ack edge
    task automatic host_access(input logic we, input wb_adr_t adr, input wb_sel_t sel,
                               input wb_dat_t wdat, output wb_dat_t rdat,
                               output int waited);
        waited     = 0;
        host_cyc   = 1'b1;
        host_stb   = 1'b1;
        host_we    = we;
        host_adr   = adr;
        host_sel   = sel;
        host_dat_w = wdat;
        do begin
            step();
            waited++;
            if (waited > MAX_ACK_WAIT) begin
                report_failure($sformatf("host access to %h got no ack", adr));
            end
        end while (!host_ack);
        rdat = host_dat_r;    // valid while ack is high
        step();
        host_cyc = 1'b0;
        host_stb = 1'b0;
        host_we  = 1'b0;
    endtask

    task automatic host_write(input wb_adr_t adr, input wb_sel_t sel, input wb_dat_t dat);
        wb_dat_t unused;
        int      waited;
        host_access(1'b1, adr, sel, dat, unused, waited);
    endtask

    task automatic host_read(input wb_adr_t adr, output wb_dat_t dat);
        int waited;
        host_access(1'b0, adr, 4'hF, '0, dat, waited);
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (4) step();
        rst_n = 1'b1;
        step();
        check_flag("halted_o", halted, 1'b0);
        check_flag("illegal_o", illegal, 1'b0);
    endtask

    // full words and single byte lanes through the host port
    task automatic host_bus_selftest();
        wb_dat_t rdat;
        host_write(32'h300, 4'hF, 32'hA5A5_5A5A);
        host_write(32'h304, 4'hF, 32'h0000_0000);
        host_read(32'h300, rdat);
        check_word("host_dat_o", rdat, 32'hA5A5_5A5A);
        host_write(32'h304, 4'b0100, 32'h00CC_0000);
        host_write(32'h304, 4'b0001, 32'h1122_3344);    // only lane 0 lands
        host_read(32'h304, rdat);
        check_word("host_dat_o", rdat, 32'h00CC_0044);
        host_read(32'h300, rdat);
        check_word("host_dat_o", rdat, 32'hA5A5_5A5A);
    endtask

    task automatic run_program(input int base);
        int      n;
        int      m;
        int      pairs;
        int      gap;
        int      idx;
        int      waited;
        wb_dat_t rdat;
        n     = pat[base];
        m     = pat[base+1+n];
        pairs = base + 2 + n;
        apply_reset();
        for (int i = 0; i < n; i++) host_write(wb_adr_t'(4*i), 4'hF, pat[base+1+i]);
        for (int j = 0; j < m; j++) host_write(pat[pairs+2*j], 4'hF, '0); // no stale results
        run = 1'b1;
        step();
        run = 1'b0;
        while (!halted) begin
            take_bits(3, gap);
            repeat (gap) step();
            if (!halted) begin
                take_bits(6, idx);
                idx = idx % n;
                host_access(1'b0, wb_adr_t'(4*idx), 4'hF, '0, rdat, waited);
                check_word("host_dat_o", rdat, pat[base+1+idx]);
                if (waited > MAX_POLL_WAIT) begin
                    report_failure($sformatf("host poll of %h waited %0d cycles for ack",
                                             4*idx, waited));
                end
            end
        end
        check_flag("illegal_o", illegal, pat[pairs+2*m+1][0]);
        repeat (8) step();    // halted core stays halted
        check_flag("halted_o", halted, pat[pairs+2*m][0]);
        check_flag("illegal_o", illegal, pat[pairs+2*m+1][0]);
        for (int j = 0; j < m; j++) begin
            host_read(pat[pairs+2*j], rdat);
            check_word("host_dat_o", rdat, pat[pairs+2*j+1]);
        end
    endtask

    initial begin
        int p;
        rst_n          = 1'b0;
        run            = 1'b0;
        host_cyc       = 1'b0;
        host_stb       = 1'b0;
        host_we        = 1'b0;
        host_adr       = '0;
        host_sel       = '0;
        host_dat_w     = '0;
        lfsr_q         = 32'h913a_e1c1;
        total_words    = 0;
        patterns_ready = 1'b0;
        $readmemh("sim/program_patterns.hex", pat);
        p = 0;
        while (pat[p] != 0) begin    // size the watchdog
            total_words += pat[p];
            p = p + 4 + pat[p] + 2 * pat[p+1+pat[p]];
        end
        if (total_words == 0) report_failure("pattern file holds no program");
        patterns_ready = 1'b1;
        apply_reset();
        host_bus_selftest();
        p = 0;
        while (pat[p] != 0) begin
            run_program(p);
            p = p + 4 + pat[p] + 2 * pat[p+1+pat[p]];
        end
        step();
        if (UUT.u_arbiter.u_props.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("%0d bus assertion failures", UUT.u_arbiter.u_props.fail_count);
            $display("RESULT: FAIL");
            $fatal(1, "bus assertions failed");
        end
    end

    // bus protocol violations end the run at once
    always @(negedge clk) begin
        if (UUT.u_arbiter.u_props.fail_count != 0) begin
            report_failure("a bus assertion failed during the run");
        end
    end

    initial begin
        wait (patterns_ready);
        repeat (40 * total_words + 2000) @(posedge clk);
        report_failure("watchdog: the run did not finish in time");
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+common
common/rv_isa_pkg.sv
common/wb_pkg.sv
core/control.sv
core/rv_core.sv
hdl/wb_arbiter.sv
hdl/wb_ram.sv
hdl/rv_soc.sv
sim/rv_soc_properties.sv
sim/tb_rv_soc.sv
